/* sources.f */
hw/sdcache_pkg.sv
hw/tag_store.sv
hw/cache_ctrl.sv
hw/blk_mover.sv
hw/cache_ram_arb.sv
hw/sdcache_top.sv
sim/tb_sdcache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the block cache testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_sdcache \
  -f sources.f

./obj_dir/Vtb_sdcache | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

/* sim/tb_sdcache.sv */
////////////////////
// Testbench for the block cache: LFSR traffic, byte device model and flat memory model
// Runs reset, fill, hit, eviction and random tests, then prints the verdict
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_sdcache import sdcache_pkg::*;;

  localparam int CACHE_DEPTH = 8;
  localparam int BLOCK_BYTES = 64;
  localparam int OFF_W       = $clog2(BLOCK_BYTES);
  localparam int BLK_W       = ADDR_W - OFF_W;
  localparam int WIDX_W      = OFF_W - WORD_LSB;           // Word within block
  localparam int RBLK_W      = $clog2(4*CACHE_DEPTH);      // Random block span
  localparam int GAP_BITS    = 3;
  localparam int MAX_GAP     = (1 << GAP_BITS) - 1;
  localparam int N_RAND      = 300;
  localparam int N_REQ       = 4 + 16 + 3 + N_RAND;        // Requests over all tests
  // Worst block move is write-back plus fill, each byte stalled up to MAX_GAP
  localparam int WATCHDOG_NS = (N_REQ + 10) * BLOCK_BYTES * 2 * (MAX_GAP + 2) * 40;
  localparam logic [31:0] SEED = 32'hd65a_8c83;

  logic             clka, i_rrst_x;
  logic             i_ren;
  be_t              i_wen;
  addr_t            i_addr;
  word_t            i_wdata, o_rdata;
  logic             o_busy, o_dev_req, o_dev_rw;
  logic [BLK_W-1:0] o_dev_blk;
  logic             i_dev_rd_en, o_dev_wr_valid, i_dev_wr_take;
  byte_t            i_dev_rd_data, o_dev_wr_data;

  logic [31:0]      stim_lfsr, dev_lfsr;   // Separate streams per process
  byte_t            dev_mem   [int];       // Device contents once written back
  byte_t            model_mem [int];       // User writes
  logic             log_rw    [$];         // Device requests in order
  logic [BLK_W-1:0] log_blk   [$];
  int               errors, wb_errors, wb_bytes;
  int               tests_run, tests_failed;

  sdcache_top #(.CACHE_DEPTH(CACHE_DEPTH), .BLOCK_BYTES(BLOCK_BYTES)) i_dut (
    .i_rrst_x, .clka, .i_ren, .i_wen, .i_addr, .i_wdata, .o_rdata, .o_busy,
    .o_dev_req, .o_dev_rw, .o_dev_blk, .i_dev_rd_en, .i_dev_rd_data,
    .o_dev_wr_valid, .o_dev_wr_data, .i_dev_wr_take
  );

  initial begin
    clka = 1'b0;
    forever #20 clka = ~clka;  // 40 ns period
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////
  // Random numbers
  ////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  // One step per bit taken
  task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      st = lfsr_step(st);
      v  = {v[30:0], st[0]};
    end
  endtask

  ////////////////////
  // Memory models
  ////////////////////
  // Initial device contents, every address bit folded in
  function automatic byte_t dev_pattern(input int a);
    logic [23:0] v;
    v = a[23:0];
    return v[7:0] ^ {v[12:8], v[15:13]} ^ {v[19:16], v[23:20]} ^ 8'h6b;
  endfunction

  function automatic byte_t dev_byte(input int a);
    if (dev_mem.exists(a)) return dev_mem[a];
    return dev_pattern(a);
  endfunction

  function automatic byte_t model_byte(input int a);
    if (model_mem.exists(a)) return model_mem[a];
    return dev_pattern(a);                       // Untouched bytes still match the device
  endfunction

  function automatic word_t model_word(input addr_t a);
    word_t w;
    int    base;
    base = int'(a) & ~3;
    for (int b = 0; b < BE_W; b++) begin
      w[b*8 +: 8] = model_byte(base + b);      // Lane b holds byte b
    end
    return w;
  endfunction

  task automatic model_write(input addr_t a, input be_t be, input word_t wd);
    int base;
    base = int'(a) & ~3;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) model_mem[base + b] = wd[b*8 +: 8];  // Merge enabled bytes only
    end
  endtask

  function automatic addr_t word_addr(input logic [BLK_W-1:0] blk,
                                      input logic [WIDX_W-1:0] w);
    return {blk, w, {WORD_LSB{1'b0}}};
  endfunction

  ////////////////////
  // Block device
  ////////////////////
  task automatic supply_block(input int base);
    logic [31:0] g;
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      take_bits(dev_lfsr, GAP_BITS, g);
      repeat (int'(g)) begin                   // Stall before this byte
        @(posedge clka);
        #2;
      end
      i_dev_rd_en   = 1'b1;
      i_dev_rd_data = dev_byte(base + i);
      @(posedge clka);
      #2;
      i_dev_rd_en = 1'b0;
    end
  endtask

  task automatic collect_block(input int base);
    logic [31:0] g;
    byte_t       b;
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      while (!o_dev_wr_valid) begin
        @(posedge clka);
        #2;
      end
      take_bits(dev_lfsr, GAP_BITS, g);
      repeat (int'(g)) begin                   // Valid must hold meanwhile
        @(posedge clka);
        #2;
      end
      assert (o_dev_wr_valid) else begin
        $display("ERR %0t o_dev_wr_valid got %b exp 1", $time, o_dev_wr_valid);
        wb_errors++;
      end
      b = o_dev_wr_data;
      assert (b == model_byte(base + i)) else begin
        $display("ERR %0t o_dev_wr_data got %h exp %h (byte %0h)",
                 $time, b, model_byte(base + i), base + i);
        wb_errors++;
      end
      dev_mem[base + i] = b;
      wb_bytes++;
      i_dev_wr_take = 1'b1;
      @(posedge clka);
      #2;
      i_dev_wr_take = 1'b0;
      assert (!o_dev_wr_valid) else begin      // Drops until the next word is read
        $display("ERR %0t o_dev_wr_valid got %b exp 0", $time, o_dev_wr_valid);
        wb_errors++;
      end
    end
  endtask

  initial begin : dev_model
    int base;
    dev_lfsr      = {SEED[15:0], SEED[31:16]};
    i_dev_rd_en   = 1'b0;
    i_dev_rd_data = '0;
    i_dev_wr_take = 1'b0;
    wb_errors     = 0;
    wb_bytes      = 0;
    forever begin
      @(posedge clka);
      #2;
      if (o_dev_req) begin
        log_rw.push_back(o_dev_rw);
        log_blk.push_back(o_dev_blk);
        base = int'(o_dev_blk) * BLOCK_BYTES;
        if (o_dev_rw) collect_block(base);
        else supply_block(base);
      end
    end
  end

  ////////////////////
  // User port
  ////////////////////
  // One request, then wait out busy and count its cycles
  task automatic access(input logic rd, input be_t be, input addr_t a, input word_t wd,
                        output int busy_cyc);
    while (o_busy) begin
      @(posedge clka);
      #2;
    end
    i_ren   = rd;
    i_wen   = be;
    i_addr  = a;
    i_wdata = wd;
    @(posedge clka);
    #2;
    i_ren    = 1'b0;
    i_wen    = '0;
    busy_cyc = 0;
    while (o_busy) begin
      busy_cyc++;
      @(posedge clka);
      #2;
    end
  endtask

  task automatic check_word(input addr_t a);
    assert (o_rdata == model_word(a)) else begin
      $display("ERR %0t o_rdata got %h exp %h (addr %h)", $time, o_rdata, model_word(a), a);
      errors++;
    end
  endtask

  task automatic check_request(input int idx, input logic rw, input logic [BLK_W-1:0] blk);
    assert (log_rw[idx] == rw) else begin
      $display("ERR %0t o_dev_rw got %b exp %b", $time, log_rw[idx], rw);
      errors++;
    end
    assert (log_blk[idx] == blk) else begin
      $display("ERR %0t o_dev_blk got %h exp %h", $time, log_blk[idx], blk);
      errors++;
    end
  endtask

  task automatic check_count(input int got, input int exp);
    assert (got == exp) else begin
      $display("ERR %0t o_dev_req count got %0d exp %0d", $time, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int err0);
    tests_run++;
    if (errors + wb_errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", name, errors + wb_errors - err0);
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin : main
    int               busy, cyc, n0, err0, wb0;
    logic [31:0]      r;
    addr_t            a, a2;
    be_t              be;
    word_t            wd;
    logic [BLK_W-1:0] blk, blk2;
    stim_lfsr    = SEED;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    i_rrst_x     = 1'b0;
    i_ren        = 1'b0;
    i_wen        = '0;
    i_addr       = '0;
    i_wdata      = '0;
    repeat (10) @(posedge clka);
    #2;
    i_rrst_x = 1'b1;

    // Reset sweep holds busy
    err0 = errors + wb_errors;
    assert (o_busy == 1'b1) else begin
      $display("ERR %0t o_busy got %b exp 1", $time, o_busy);
      errors++;
    end
    cyc = 0;
    while (o_busy && cyc < CACHE_DEPTH + 4) begin
      @(posedge clka);
      #2;
      cyc++;
    end
    assert (!o_busy) else begin
      $display("Busy still high %0d cycles after reset release", cyc);
      errors++;
    end
    check_count(log_rw.size(), 0);
    end_test("reset sweep", err0);

    // Untouched blocks come from the device
    err0 = errors + wb_errors;
    for (int i = 0; i < 4; i++) begin
      take_bits(stim_lfsr, WIDX_W, r);
      blk = BLK_W'('h100) + BLK_W'(i);
      a   = word_addr(blk, r[WIDX_W-1:0]);
      n0  = log_rw.size();
      access(1'b1, '0, a, '0, busy);
      check_word(a);
      check_count(log_rw.size(), n0 + 1);
      if (log_rw.size() == n0 + 1) check_request(n0, 1'b0, blk);
    end
    end_test("read miss fill", err0);

    // Write with enables, read back as a hit
    err0 = errors + wb_errors;
    for (int i = 0; i < 8; i++) begin
      take_bits(stim_lfsr, WIDX_W, r);
      a = word_addr(BLK_W'('h200), r[WIDX_W-1:0]);
      take_bits(stim_lfsr, BE_W, r);
      be = r[BE_W-1:0];
      if (be == '0) be = '1;
      take_bits(stim_lfsr, DATA_W, r);
      wd = r;
      access(1'b0, be, a, wd, busy);
      model_write(a, be, wd);
      n0 = log_rw.size();
      access(1'b1, '0, a, '0, busy);
      assert (busy == 1) else begin
        $display("ERR %0t o_busy cycles got %0d exp 1", $time, busy);
        errors++;
      end
      check_count(log_rw.size(), n0);
      check_word(a);
    end
    end_test("byte-enable write then hit", err0);

    // Same line, other tag: write-back of the dirty block, then fill
    err0 = errors + wb_errors;
    blk  = BLK_W'('h300);
    blk2 = BLK_W'('h300 + CACHE_DEPTH);
    take_bits(stim_lfsr, WIDX_W, r);
    a  = word_addr(blk, r[WIDX_W-1:0]);
    a2 = word_addr(blk2, r[WIDX_W-1:0]);
    take_bits(stim_lfsr, DATA_W, r);
    access(1'b0, '1, a, r, busy);
    model_write(a, '1, r);
    n0  = log_rw.size();
    wb0 = wb_bytes;
    access(1'b1, '0, a2, '0, busy);
    check_word(a2);
    check_count(log_rw.size(), n0 + 2);
    if (log_rw.size() == n0 + 2) begin
      check_request(n0, 1'b1, blk);      // Old block leaves first
      check_request(n0 + 1, 1'b0, blk2);
    end
    assert (wb_bytes - wb0 == BLOCK_BYTES) else begin
      $display("ERR %0t write-back bytes got %0d exp %0d", $time, wb_bytes - wb0, BLOCK_BYTES);
      errors++;
    end
    access(1'b1, '0, a, '0, busy);       // Comes back from device memory
    check_word(a);
    end_test("dirty eviction", err0);

    // Mixed traffic over four blocks per line
    err0 = errors + wb_errors;
    for (int i = 0; i < N_RAND; i++) begin
      take_bits(stim_lfsr, RBLK_W, r);
      blk = BLK_W'('h1000) + BLK_W'(r[RBLK_W-1:0]);
      take_bits(stim_lfsr, WIDX_W, r);
      a = word_addr(blk, r[WIDX_W-1:0]);
      take_bits(stim_lfsr, 1, r);
      if (r[0]) begin
        access(1'b1, '0, a, '0, busy);
        check_word(a);
      end else begin
        take_bits(stim_lfsr, BE_W, r);
        be = r[BE_W-1:0];
        if (be == '0) be = '1;           // Zero enables would be no request
        take_bits(stim_lfsr, DATA_W, r);
        wd = r;
        access(1'b0, be, a, wd, busy);
        model_write(a, be, wd);
      end
    end
    end_test("random mixed traffic", err0);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors + wb_errors);
    if (errors + wb_errors == 0 && tests_failed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/sdcache_top.sv */
////////////////////
// Block cache top: user word port in front, byte block device behind
////////////////////
`timescale 1ns/1ps
`default_nettype none

module sdcache_top import sdcache_pkg::*; #(
  parameter  int CACHE_DEPTH = 8,
  parameter  int BLOCK_BYTES = 64,
  localparam int BLK_W = ADDR_W - $clog2(BLOCK_BYTES)
) (
  input  wire              i_rrst_x,
  input  wire              clka,
  // User port
  input  wire              i_ren,
  input  wire be_t         i_wen,
  input  wire addr_t       i_addr,
  input  wire word_t       i_wdata,
  output word_t            o_rdata,
  output logic             o_busy,
  // Block device
  output logic             o_dev_req,
  output logic             o_dev_rw,
  output logic [BLK_W-1:0] o_dev_blk,
  input  wire              i_dev_rd_en,
  input  wire byte_t       i_dev_rd_data,
  output logic             o_dev_wr_valid,
  output byte_t            o_dev_wr_data,
  input  wire              i_dev_wr_take
);

  // Tag store
  addr_t            tag_addr;
  logic             tag_set, tag_dirty_in;
  logic             tag_valid, tag_hit, tag_dirty, tag_ready;
  logic [BLK_W-1:0] tag_old_blk;
  // Block request
  logic             xfer_req, xfer_rw, xfer_done;
  logic [BLK_W-1:0] xfer_blk;
  // RAM peers
  logic             m_req, m_gnt, c_req, c_gnt;
  addr_t            m_addr, c_addr;
  be_t              m_be, c_be;
  word_t            m_wdata, m_rdata, c_wdata;

  tag_store #(.CACHE_DEPTH(CACHE_DEPTH), .BLOCK_BYTES(BLOCK_BYTES)) u_tag (
    .clka, .i_rrst_x, .i_addr(tag_addr), .i_set(tag_set), .i_dirty(tag_dirty_in),
    .o_valid(tag_valid), .o_hit(tag_hit), .o_dirty(tag_dirty),
    .o_old_blk(tag_old_blk), .o_ready(tag_ready)
  );

  cache_ctrl #(.BLOCK_BYTES(BLOCK_BYTES)) u_ctrl (
    .clka, .i_rrst_x, .i_ren, .i_wen, .i_addr, .i_wdata, .o_busy,
    .o_tag_addr(tag_addr), .o_tag_set(tag_set), .o_tag_dirty(tag_dirty_in),
    .i_tag_valid(tag_valid), .i_tag_hit(tag_hit), .i_tag_dirty(tag_dirty),
    .i_tag_old_blk(tag_old_blk), .i_tag_ready(tag_ready),
    .o_xfer_req(xfer_req), .o_xfer_rw(xfer_rw), .o_xfer_blk(xfer_blk),
    .i_xfer_done(xfer_done),
    .o_ram_req(c_req), .o_ram_addr(c_addr), .o_ram_be(c_be), .o_ram_wdata(c_wdata),
    .i_ram_gnt(c_gnt)
  );

  blk_mover #(.BLOCK_BYTES(BLOCK_BYTES)) u_mover (
    .clka, .i_rrst_x,
    .i_xfer_req(xfer_req), .i_xfer_rw(xfer_rw), .i_xfer_blk(xfer_blk),
    .o_xfer_done(xfer_done),
    .o_dev_req, .o_dev_rw, .o_dev_blk, .i_dev_rd_en, .i_dev_rd_data,
    .o_dev_wr_valid, .o_dev_wr_data, .i_dev_wr_take,
    .o_ram_req(m_req), .o_ram_addr(m_addr), .o_ram_be(m_be), .o_ram_wdata(m_wdata),
    .i_ram_gnt(m_gnt), .i_ram_rdata(m_rdata)
  );

  // o_rdata comes straight from the controller's read register
  cache_ram_arb #(.CACHE_DEPTH(CACHE_DEPTH), .BLOCK_BYTES(BLOCK_BYTES)) u_ram (
    .clka, .i_rrst_x,
    .i_m_req(m_req), .i_m_addr(m_addr), .i_m_be(m_be), .i_m_wdata(m_wdata),
    .o_m_gnt(m_gnt), .o_m_rdata(m_rdata),
    .i_c_req(c_req), .i_c_addr(c_addr), .i_c_be(c_be), .i_c_wdata(c_wdata),
    .o_c_gnt(c_gnt), .o_c_rdata(o_rdata)
  );

endmodule

`default_nettype wire

/* hw/cache_ram_arb.sv */
////////////////////
// Single-port byte-write cache RAM shared by mover and controller
// Mover wins; each peer keeps its own read register
////////////////////
`timescale 1ns/1ps
`default_nettype none

module cache_ram_arb import sdcache_pkg::*; #(
  parameter  int CACHE_DEPTH = 8,
  parameter  int BLOCK_BYTES = 64,
  localparam int DEPTH = CACHE_DEPTH * BLOCK_BYTES / BE_W,
  localparam int AW    = $clog2(DEPTH)
) (
  input  wire        clka,
  input  wire        i_rrst_x,
  // Mover port
  input  wire        i_m_req,
  input  wire addr_t i_m_addr,
  input  wire be_t   i_m_be,
  input  wire word_t i_m_wdata,
  output logic       o_m_gnt,
  output word_t      o_m_rdata,
  // Controller port
  input  wire        i_c_req,
  input  wire addr_t i_c_addr,
  input  wire be_t   i_c_be,
  input  wire word_t i_c_wdata,
  output logic       o_c_gnt,
  output word_t      o_c_rdata
);

  word_t mem [DEPTH];

  logic [AW-1:0] w_idx;
  be_t           w_we;
  word_t         w_wdata;

  ////////////////////
  // Arbitration
  ////////////////////
  assign o_m_gnt = i_m_req;
  assign o_c_gnt = i_c_req & ~i_m_req;

  assign w_idx   = o_m_gnt ? i_m_addr[WORD_LSB +: AW] : i_c_addr[WORD_LSB +: AW];
  assign w_wdata = o_m_gnt ? i_m_wdata : i_c_wdata;
  assign w_we    = o_m_gnt ? i_m_be : (o_c_gnt ? i_c_be : '0);  // No write without grant

  // Byte lanes
  always_ff @(posedge clka) begin
    for (int b = 0; b < BE_W; b++) begin
      if (w_we[b]) begin
        mem[w_idx][b*BYTE_W +: BYTE_W] <= w_wdata[b*BYTE_W +: BYTE_W];
      end
    end
  end

  // Read-first, one cycle latency, per-peer output
  always_ff @(posedge clka) begin
    if (!i_rrst_x) begin
      o_m_rdata <= '0;
      o_c_rdata <= '0;
    end else begin
      if (o_m_gnt && (i_m_be == '0)) begin
        o_m_rdata <= mem[w_idx];
      end
      if (o_c_gnt && (i_c_be == '0)) begin
        o_c_rdata <= mem[w_idx];   // Holds across writes and mover traffic
      end
    end
  end

endmodule

`default_nettype wire

/* hw/blk_mover.sv */
////////////////////
// Moves one block between cache RAM and the byte-wide block device
// Fill packs bytes into lanes, write-back reads a word per byte
////////////////////
`timescale 1ns/1ps
`default_nettype none

module blk_mover import sdcache_pkg::*; #(
  parameter  int BLOCK_BYTES = 64,
  localparam int OFF_W = $clog2(BLOCK_BYTES),
  localparam int BLK_W = ADDR_W - OFF_W
) (
  input  wire              clka,
  input  wire              i_rrst_x,
  // Request from controller
  input  wire              i_xfer_req,
  input  wire              i_xfer_rw,
  input  wire [BLK_W-1:0]  i_xfer_blk,
  output logic             o_xfer_done,
  // Block device
  output logic             o_dev_req,
  output logic             o_dev_rw,
  output logic [BLK_W-1:0] o_dev_blk,
  input  wire              i_dev_rd_en,
  input  wire byte_t       i_dev_rd_data,
  output logic             o_dev_wr_valid,
  output byte_t            o_dev_wr_data,
  input  wire              i_dev_wr_take,
  // Cache RAM
  output logic             o_ram_req,
  output addr_t            o_ram_addr,
  output be_t              o_ram_be,
  output word_t            o_ram_wdata,
  input  wire              i_ram_gnt,
  input  wire word_t       i_ram_rdata
);

  logic             r_act;     // Transfer running
  logic             r_rd_req;  // Write-back word read pending
  logic             r_rw;
  logic [BLK_W-1:0] r_blk;
  logic [OFF_W-1:0] r_cnt;     // Byte within block
  be_t              r_be;      // One-hot lane for fill
  logic             w_fill_wr;
  logic             w_last;

  assign w_fill_wr = r_act & ~r_rw & i_dev_rd_en;
  assign w_last    = (r_cnt == OFF_W'(BLOCK_BYTES-1));

  assign o_dev_rw      = r_rw;
  assign o_dev_blk     = r_blk;
  assign o_ram_addr    = {r_blk, r_cnt};
  assign o_ram_req     = r_rw ? (r_act & r_rd_req) : w_fill_wr;
  assign o_ram_be      = w_fill_wr ? r_be : '0;
  assign o_ram_wdata   = {BE_W{i_dev_rd_data}};  // Same byte on every lane
  // Lane of the current byte in the last word read
  assign o_dev_wr_data = byte_t'(i_ram_rdata >> {r_cnt[WORD_LSB-1:0], 3'b000});

  ////////////////////
  // Control
  ////////////////////
  always_ff @(posedge clka) begin
    if (!i_rrst_x) begin
      r_act          <= 1'b0;
      r_rd_req       <= 1'b0;
      o_dev_req      <= 1'b0;
      o_dev_wr_valid <= 1'b0;
      o_xfer_done    <= 1'b0;
    end else begin
      o_dev_req   <= 1'b0;
      o_xfer_done <= 1'b0;
      if (!r_act) begin
        if (i_xfer_req) begin
          r_act     <= 1'b1;
          o_dev_req <= 1'b1;
          r_rd_req  <= i_xfer_rw;  // Write-back starts with a RAM read
        end
      end else if (!r_rw) begin
        if (i_dev_rd_en && w_last) begin
          r_act       <= 1'b0;
          o_xfer_done <= 1'b1;
        end
      end else if (r_rd_req) begin
        if (i_ram_gnt) begin
          r_rd_req       <= 1'b0;
          o_dev_wr_valid <= 1'b1;  // Read data lands with this edge
        end
      end else if (o_dev_wr_valid && i_dev_wr_take) begin
        o_dev_wr_valid <= 1'b0;
        if (w_last) begin
          r_act       <= 1'b0;
          o_xfer_done <= 1'b1;
        end else begin
          r_rd_req <= 1'b1;        // Fetch next byte's word
        end
      end
    end
  end

  // Block number, byte counter and lane
  always_ff @(posedge clka) begin
    if (!r_act && i_xfer_req) begin
      r_rw  <= i_xfer_rw;
      r_blk <= i_xfer_blk;
      r_cnt <= '0;
      r_be  <= be_t'(1);
    end else if (w_fill_wr) begin
      r_cnt <= r_cnt + 1'b1;
      r_be  <= {r_be[BE_W-2:0], r_be[BE_W-1]};  // Rotate to next lane
    end else if (r_act && r_rw && o_dev_wr_valid && i_dev_wr_take) begin
      r_cnt <= r_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/cache_ctrl.sv */
////////////////////
// User-port FSM: lookup, optional write-back, fill, then word access and tag update
// Busy is high in every state but IDLE
////////////////////
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import sdcache_pkg::*; #(
  parameter  int BLOCK_BYTES = 64,
  localparam int OFF_W = $clog2(BLOCK_BYTES),
  localparam int BLK_W = ADDR_W - OFF_W
) (
  input  wire              clka,
  input  wire              i_rrst_x,
  // User port
  input  wire              i_ren,
  input  wire be_t         i_wen,
  input  wire addr_t       i_addr,
  input  wire word_t       i_wdata,
  output logic             o_busy,
  // Tag store
  output addr_t            o_tag_addr,
  output logic             o_tag_set,
  output logic             o_tag_dirty,
  input  wire              i_tag_valid,
  input  wire              i_tag_hit,
  input  wire              i_tag_dirty,
  input  wire [BLK_W-1:0]  i_tag_old_blk,
  input  wire              i_tag_ready,
  // Block mover
  output logic             o_xfer_req,
  output logic             o_xfer_rw,   // 1 = write-back
  output logic [BLK_W-1:0] o_xfer_blk,
  input  wire              i_xfer_done,
  // Cache RAM
  output logic             o_ram_req,
  output addr_t            o_ram_addr,
  output be_t              o_ram_be,
  output word_t            o_ram_wdata,
  input  wire              i_ram_gnt
);

  ctrl_state_t r_st0, r_st1, r_st2;  // Current state and queued next two

  // Captured request
  addr_t r_addr;
  word_t r_wdata;
  be_t   r_be;
  logic  r_dirty;                    // Dirty bit for SET_TAG

  logic  w_req;

  assign w_req       = i_ren | (|i_wen);
  assign o_busy      = (r_st0 != IDLE);
  assign o_tag_addr  = (r_st0 == IDLE) ? i_addr : r_addr;  // Lookup live address in IDLE
  assign o_tag_set   = (r_st0 == SET_TAG);
  assign o_tag_dirty = r_dirty;

  assign o_ram_req   = (r_st0 == SET_TAG);  // Held until granted
  assign o_ram_addr  = r_addr;
  assign o_ram_be    = r_be;
  assign o_ram_wdata = r_wdata;

  ////////////////////
  // State sequence
  ////////////////////
  always_ff @(posedge clka) begin
    if (!i_rrst_x) begin
      r_st0      <= INIT;
      r_st1      <= INIT;
      r_st2      <= INIT;
      o_xfer_req <= 1'b0;
    end else begin
      o_xfer_req <= 1'b0;                // Strobe by default
      case (r_st0)
        INIT: begin
          if (i_tag_ready) begin
            r_st0 <= IDLE;
            r_st1 <= IDLE;
            r_st2 <= IDLE;
          end
        end
        IDLE: begin
          if (w_req) begin
            if (i_tag_hit) begin         // Hit: word access only
              r_st0 <= SET_TAG;
              r_st1 <= IDLE;
              r_st2 <= IDLE;
            end else if (i_tag_valid && i_tag_dirty) begin
              r_st0 <= WRITE_BLOCK;      // Evict old block first
              r_st1 <= READ_BLOCK;
              r_st2 <= SET_TAG;
            end else begin
              r_st0 <= READ_BLOCK;
              r_st1 <= SET_TAG;
              r_st2 <= IDLE;
            end
          end
        end
        WRITE_BLOCK, READ_BLOCK: begin
          o_xfer_req <= 1'b1;
          r_st0      <= WAIT;            // Queue untouched
        end
        WAIT: begin
          if (i_xfer_done) begin
            r_st0 <= r_st1;
            r_st1 <= r_st2;
            r_st2 <= IDLE;
          end
        end
        SET_TAG: begin
          if (i_ram_gnt) begin
            r_st0 <= r_st1;
            r_st1 <= r_st2;
            r_st2 <= IDLE;
          end
        end
        default: r_st0 <= IDLE;
      endcase
    end
  end

  ////////////////////
  // Request and transfer payload
  ////////////////////
  always_ff @(posedge clka) begin
    if (r_st0 == IDLE) begin
      r_addr  <= i_addr;
      r_wdata <= i_wdata;
      r_be    <= i_wen;
      // A hit keeps an existing dirty mark, a fill starts clean
      r_dirty <= (|i_wen) | (i_tag_hit & i_tag_dirty);
    end
    if (r_st0 == WRITE_BLOCK) begin
      o_xfer_rw  <= 1'b1;
      o_xfer_blk <= i_tag_old_blk;       // Resident block of this line
    end else if (r_st0 == READ_BLOCK) begin
      o_xfer_rw  <= 1'b0;
      o_xfer_blk <= r_addr[ADDR_W-1:OFF_W];
    end
  end

endmodule

`default_nettype wire

/* hw/tag_store.sv */
////////////////////
// Direct-mapped tag store with valid and dirty bits
// Lookup is combinational, update on i_set, sweep clears all lines after reset
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tag_store import sdcache_pkg::*; #(
  parameter  int CACHE_DEPTH = 8,
  parameter  int BLOCK_BYTES = 64,
  localparam int OFF_W = $clog2(BLOCK_BYTES),
  localparam int IDX_W = $clog2(CACHE_DEPTH),
  localparam int TAG_W = ADDR_W - OFF_W - IDX_W,
  localparam int BLK_W = ADDR_W - OFF_W
) (
  input  wire              clka,
  input  wire              i_rrst_x,
  input  wire addr_t       i_addr,     // Lookup or update address
  input  wire              i_set,      // Write tag of i_addr
  input  wire              i_dirty,    // Dirty bit to store
  output logic             o_valid,
  output logic             o_hit,
  output logic             o_dirty,
  output logic [BLK_W-1:0] o_old_blk,  // Block now resident in the line
  output logic             o_ready     // Low while sweeping
);

  logic             valid_mem [CACHE_DEPTH];
  logic             dirty_mem [CACHE_DEPTH];
  logic [TAG_W-1:0] tag_mem   [CACHE_DEPTH];

  logic             r_sweep;  // Clearing lines
  logic [IDX_W-1:0] r_cnt;    // Line being cleared

  logic [IDX_W-1:0] w_idx;
  logic [TAG_W-1:0] w_tag;

  assign w_idx = i_addr[OFF_W +: IDX_W];
  assign w_tag = i_addr[ADDR_W-1 -: TAG_W];

  ////////////////////
  // Lookup
  ////////////////////
  // An update in progress reports itself as a valid hit
  assign o_valid   = i_set | valid_mem[w_idx];
  assign o_hit     = i_set | (valid_mem[w_idx] & (tag_mem[w_idx] == w_tag));
  assign o_dirty   = i_set ? i_dirty : dirty_mem[w_idx];
  assign o_old_blk = {tag_mem[w_idx], w_idx};
  assign o_ready   = ~r_sweep;

  ////////////////////
  // Sweep and update
  ////////////////////
  always_ff @(posedge clka) begin
    if (!i_rrst_x) begin
      r_sweep <= 1'b1;
      r_cnt   <= '0;
    end else if (r_sweep) begin
      valid_mem[r_cnt] <= 1'b0;  // One line per cycle
      dirty_mem[r_cnt] <= 1'b0;
      tag_mem[r_cnt]   <= '0;
      r_cnt            <= r_cnt + 1'b1;
      if (r_cnt == IDX_W'(CACHE_DEPTH-1)) begin
        r_sweep <= 1'b0;         // Last line cleared
      end
    end else if (i_set) begin
      valid_mem[w_idx] <= 1'b1;
      dirty_mem[w_idx] <= i_dirty;
      tag_mem[w_idx]   <= w_tag;
    end
  end

endmodule

`default_nettype wire

/* hw/sdcache_pkg.sv */
////////////////////
// Shared widths, word/byte split and controller states for the block cache
// Imported by every RTL module of the cache
////////////////////
`default_nettype none

package sdcache_pkg;

  ////////////////////
  // User port widths
  ////////////////////
  localparam int ADDR_W = 24;        // User byte address
  localparam int DATA_W = 32;        // User word
  localparam int BE_W   = DATA_W/8;  // One enable per byte lane

  // Byte address split below the block offset
  localparam int BYTE_W   = 8;              // Device byte width
  localparam int WORD_LSB = $clog2(BE_W);   // Lane select bits under the word address

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [BE_W-1:0]   be_t;
  typedef logic [BYTE_W-1:0] byte_t;

  ////////////////////
  // Controller states
  ////////////////////
  typedef enum logic [2:0] {
    INIT,         // Waiting for tag sweep
    IDLE,         // Accepting user requests
    WRITE_BLOCK,  // Issue write-back of old block
    READ_BLOCK,   // Issue fill of new block
    WAIT,         // Block transfer in flight
    SET_TAG       // User word access plus tag update
  } ctrl_state_t;

endpackage

`default_nettype wire
